// ==== mini_vdp.f ====
+incdir+src
src/vdp_bus_pkg.sv
src/vdp_video_pkg.sv
src/vram_port_if.sv
src/host_regs.sv
src/scanout.sv
src/vram_arbiter.sv
src/palette_out.sv
src/mini_vdp.sv
tb/tb_mini_vdp.sv

// ==== Makefile ====
# verilator build and run of the mini_vdp testbench
TOP = tb_mini_vdp

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator and run, fails unless the testbench passes"
	@echo "  clean  remove the verilator build directory"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f mini_vdp.f -o $(TOP)
	@out=$$(./obj_dir/$(TOP)); echo "$$out"; echo "$$out" | grep -q "^Result: PASSED$$"

clean:
	rm -rf obj_dir

// ==== tb/tb_mini_vdp.sv ====
/*
 * self-checking testbench for mini_vdp, concurrent assertions do the checks
 * inputs change on the falling edge, outputs sampled on the rising edge
 * register 2 and later tests assume they start well before the first vblank
 */
`default_nettype none
`timescale 1ns/1ps
`include "vdp_config.svh"

module tb_mini_vdp;

localparam int FRAME = `H_TOTAL * `V_TOTAL;   // 288 cycles
localparam int TIMEOUT_CYCLES = 6000;         // ~12 frames plus bus traffic, with margin

logic        clk, reset_i;
logic        wb_cyc_i, wb_stb_i, wb_we_i, wb_ack_o;
logic [2:0]  wb_adr_i;
logic [15:0] wb_dat_i, wb_dat_o;
logic [3:0]  red_o, green_o, blue_o;
logic        hsync_o, vsync_o, de_o, intr_o;

logic [15:0] vram_model [256];
logic [11:0] pal_model [256];
logic [31:0] lcg_state;
int          err_count, err_mark, tests_passed, tests_failed, cycle_count;
logic        rd_check, pix_en, mask_off_chk, vb_chk;   // enables, set on negedge
logic [15:0] rd_expect;

// monitor state, all updated on the rising edge
logic        rst_d, started, ack_prev, hs_prev, vs_prev, de_prev, intr_prev;
logic        hs_armed, vs_armed;
int          hs_gap, vs_gap, de_run, de_lines;
logic [8:0]  pix_count;         // visible pixels since vsync
logic [15:0] pix_word;
logic [11:0] exp_rgb, rgb_out;
logic [16:0] outs;
logic        hs_rise, vs_rise, de_fall, intr_rise;

mini_vdp mini_vdp_i (
    .clk(clk), .reset_i(reset_i),
    .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i), .wb_adr_i(wb_adr_i),
    .wb_dat_i(wb_dat_i), .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o),
    .red_o(red_o), .green_o(green_o), .blue_o(blue_o),
    .hsync_o(hsync_o), .vsync_o(vsync_o), .de_o(de_o), .intr_o(intr_o)
);

always #50 clk = ~clk;      // 100 ns period

assign rgb_out   = {red_o, green_o, blue_o};
assign outs      = {wb_ack_o, intr_o, hsync_o, vsync_o, de_o, rgb_out};
assign hs_rise   = hsync_o && !hs_prev;
assign vs_rise   = vsync_o && !vs_prev;
assign de_fall   = !de_o && de_prev;
assign intr_rise = intr_o && !intr_prev;

// pixel p is byte p of memory, word p/2, high byte on even p
always_comb begin
    pix_word = vram_model[pix_count[7:1]];
    exp_rgb  = pal_model[pix_count[0] ? pix_word[7:0] : pix_word[15:8]];
end

always @(posedge clk) begin
    rst_d     <= reset_i;
    ack_prev  <= wb_ack_o;
    hs_prev   <= hsync_o;
    vs_prev   <= vsync_o;
    de_prev   <= de_o;
    intr_prev <= intr_o;
    if (reset_i) started <= 1'b1;
    if (reset_i) begin
        hs_armed <= 1'b0;
        vs_armed <= 1'b0;
        hs_gap   <= 0;
        vs_gap   <= 0;
        de_run   <= 0;
        de_lines <= 0;
    end else begin
        hs_gap <= hs_rise ? 1 : hs_gap + 1;   // cycles since last hsync edge
        vs_gap <= vs_rise ? 1 : vs_gap + 1;
        if (hs_rise) hs_armed <= 1'b1;
        if (vs_rise) vs_armed <= 1'b1;
        de_run <= de_o ? de_run + 1 : 0;
        if (vs_rise) de_lines <= 0;
        else if (de_fall) de_lines <= de_lines + 1;   // visible lines this frame
    end
    if (vsync_o) pix_count <= '0;
    else if (de_o) pix_count <= pix_count + 1'b1;
end

// run limit
always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Result: FAILED");
        $finish;
    end
end

reset_quiet: assert property (@(posedge clk) rst_d |-> (outs == '0))
    else begin
        $display("MISMATCH at %0t: outputs {ack,intr,hs,vs,de,rgb} expected %h got %h",
                 $time, 17'h0, $sampled(outs));
        err_count++;
    end

ack_single: assert property (@(posedge clk) ack_prev |-> !wb_ack_o)
    else begin
        $display("at %0t wb_ack_o stayed high for more than one cycle", $time);
        err_count++;
    end

read_data: assert property (@(posedge clk) (rd_check && wb_ack_o) |-> (wb_dat_o == rd_expect))
    else begin
        $display("MISMATCH at %0t: wb_dat_o expected %h got %h",
                 $time, $sampled(rd_expect), $sampled(wb_dat_o));
        err_count++;
    end

pixel_colour: assert property (@(posedge clk) (pix_en && de_o) |-> (rgb_out == exp_rgb))
    else begin
        $display("MISMATCH at %0t: rgb pixel %0d expected %h got %h",
                 $time, $sampled(pix_count), $sampled(exp_rgb), $sampled(rgb_out));
        err_count++;
    end

blank_black: assert property (@(posedge clk) (started && !de_o) |-> (rgb_out == 12'h000))
    else begin
        $display("MISMATCH at %0t: rgb in blanking expected 000 got %h", $time, $sampled(rgb_out));
        err_count++;
    end

hsync_period: assert property (@(posedge clk) (hs_armed && hs_rise) |-> (hs_gap == `H_TOTAL))
    else begin
        $display("MISMATCH at %0t: hsync_o period expected %0d got %0d",
                 $time, `H_TOTAL, $sampled(hs_gap));
        err_count++;
    end

vsync_period: assert property (@(posedge clk) (vs_armed && vs_rise) |-> (vs_gap == FRAME))
    else begin
        $display("MISMATCH at %0t: vsync_o period expected %0d got %0d",
                 $time, FRAME, $sampled(vs_gap));
        err_count++;
    end

line_width: assert property (@(posedge clk) de_fall |-> (de_run == `H_VISIBLE))
    else begin
        $display("MISMATCH at %0t: de_o run length expected %0d got %0d",
                 $time, `H_VISIBLE, $sampled(de_run));
        err_count++;
    end

frame_lines: assert property (@(posedge clk) (vs_armed && vs_rise) |-> (de_lines == `V_VISIBLE))
    else begin
        $display("MISMATCH at %0t: de_o lines per frame expected %0d got %0d",
                 $time, `V_VISIBLE, $sampled(de_lines));
        err_count++;
    end

intr_masked: assert property (@(posedge clk) mask_off_chk |-> !intr_o)
    else begin
        $display("at %0t intr_o went high while the mask was clear", $time);
        err_count++;
    end

intr_at_vblank: assert property (@(posedge clk) (vb_chk && intr_rise) |-> (de_lines == `V_VISIBLE))
    else begin
        $display("at %0t intr_o rose outside vertical blank, after %0d visible lines",
                 $time, $sampled(de_lines));
        err_count++;
    end

function automatic logic [15:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[31:16];        // upper bits are the better ones
endfunction

// one wishbone cycle, held through the ack edge, stb low for a cycle after
task automatic bus_access(input logic we, input logic [2:0] adr, input logic [15:0] wdat,
                          input logic chk, input logic [15:0] exp_dat);
    @(negedge clk);
    wb_cyc_i  = 1'b1;
    wb_stb_i  = 1'b1;
    wb_we_i   = we;
    wb_adr_i  = adr;
    wb_dat_i  = wdat;
    rd_check  = chk;
    rd_expect = exp_dat;
    do begin
        @(negedge clk);
    end while (!wb_ack_o);
    @(negedge clk);                 // ack edge has passed
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    rd_check = 1'b0;
endtask

task automatic write_reg(input logic [2:0] adr, input logic [15:0] dat);
    bus_access(1'b1, adr, dat, 1'b0, 16'h0);
endtask

task automatic check_reg(input logic [2:0] adr, input logic [15:0] exp_dat);
    bus_access(1'b0, adr, 16'h0, 1'b1, exp_dat);
endtask

task automatic wait_vsync();        // next rising edge of vsync_o
    @(negedge clk);
    while (vsync_o) @(negedge clk);
    while (!vsync_o) @(negedge clk);
endtask

task automatic wait_intr(input logic level, input int limit);
    int n;
    n = 0;
    while (intr_o !== level && n < limit) begin
        @(negedge clk);
        n++;
    end
    if (intr_o !== level) begin
        $display("intr_o did not go to %b within %0d cycles", level, limit);
        err_count++;
    end
endtask

task automatic end_test(input string name);
    if (err_count == err_mark) begin
        tests_passed++;
        $display("test %s: ok", name);
    end else begin
        tests_failed++;
        $display("test %s: failed with %0d errors", name, err_count - err_mark);
    end
    err_mark = err_count;
endtask

initial begin
    int          i;
    logic [15:0] d;
    clk = 1'b0;
    reset_i = 1'b1;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i = 1'b0;
    wb_adr_i = '0;
    wb_dat_i = '0;
    rd_check = 1'b0;
    rd_expect = '0;
    pix_en = 1'b0;
    mask_off_chk = 1'b0;
    vb_chk = 1'b0;
    rst_d = 1'b0;
    started = 1'b0;
    ack_prev = 1'b0;
    pix_count = '0;
    lcg_state = 32'hf90796d3;
    err_count = 0;
    err_mark = 0;
    tests_passed = 0;
    tests_failed = 0;
    cycle_count = 0;

    repeat (8) @(negedge clk);
    reset_i = 1'b0;
    repeat (2) @(negedge clk);      // first cycle after reset is checked too
    end_test("reset state");

    // registers keep only their own width
    write_reg(vdp_bus_pkg::REG_VRAM_ADDR, 16'h1234);
    check_reg(vdp_bus_pkg::REG_VRAM_ADDR, 16'h0034);
    write_reg(vdp_bus_pkg::REG_PAL_ADDR, 16'habcd);
    check_reg(vdp_bus_pkg::REG_PAL_ADDR, 16'h00cd);
    check_reg(vdp_bus_pkg::REG_PAL_DATA, 16'h0000);
    check_reg(vdp_bus_pkg::REG_PAL_ADDR, 16'h00ce);     // data read steps the address
    write_reg(vdp_bus_pkg::REG_INT_CTRL, 16'h0101);
    check_reg(vdp_bus_pkg::REG_INT_CTRL, 16'h0001);
    write_reg(vdp_bus_pkg::REG_INT_CTRL, 16'h0100);
    check_reg(vdp_bus_pkg::REG_INT_CTRL, 16'h0000);
    end_test("register readback");

    // 48 words away from the displayed area, scanout keeps fetching meanwhile
    write_reg(vdp_bus_pkg::REG_VRAM_ADDR, 16'h0080);
    for (i = 0; i < 48; i++) begin
        d = next_random();
        vram_model[8'h80 + i] = d;
        write_reg(vdp_bus_pkg::REG_VRAM_DATA, d);
    end
    check_reg(vdp_bus_pkg::REG_VRAM_ADDR, 16'h00b0);
    write_reg(vdp_bus_pkg::REG_VRAM_ADDR, 16'h0080);
    for (i = 0; i < 48; i++) check_reg(vdp_bus_pkg::REG_VRAM_DATA, vram_model[8'h80 + i]);
    end_test("vram access");

    // full palette, then the 64 displayed words
    write_reg(vdp_bus_pkg::REG_PAL_ADDR, 16'h0000);
    for (i = 0; i < 256; i++) begin
        d = next_random();
        pal_model[i] = d[11:0];
        write_reg(vdp_bus_pkg::REG_PAL_DATA, d);
    end
    write_reg(vdp_bus_pkg::REG_VRAM_ADDR, 16'h0000);
    for (i = 0; i < 64; i++) begin
        d = next_random();
        vram_model[i] = d;
        write_reg(vdp_bus_pkg::REG_VRAM_DATA, d);
    end
    wait_vsync();
    pix_en = 1'b1;                  // one whole frame
    wait_vsync();
    pix_en = 1'b0;
    if (pix_count != `H_VISIBLE * `V_VISIBLE) begin
        $display("MISMATCH at %0t: de_o pixels per frame expected %0d got %0d",
                 $time, `H_VISIBLE * `V_VISIBLE, pix_count);
        err_count++;
    end
    end_test("pixel output");

    repeat (3) wait_vsync();
    end_test("raster shape");

    // interrupt writes right after vsync, far from the next strobe
    wait_vsync();
    write_reg(vdp_bus_pkg::REG_INT_CTRL, 16'h0100);     // clear, mask off
    mask_off_chk = 1'b1;
    wait_vsync();
    check_reg(vdp_bus_pkg::REG_INT_CTRL, 16'h0100);     // pending, still masked
    mask_off_chk = 1'b0;
    write_reg(vdp_bus_pkg::REG_INT_CTRL, 16'h0001);
    wait_intr(1'b1, 8);
    write_reg(vdp_bus_pkg::REG_INT_CTRL, 16'h0101);     // clear, mask stays on
    wait_intr(1'b0, 8);
    vb_chk = 1'b1;
    wait_intr(1'b1, 2 * FRAME);
    vb_chk = 1'b0;
    end_test("interrupt");

    $display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, err_count);
    if (tests_failed == 0 && err_count == 0) begin
        $display("Result: PASSED");
    end else begin
        $display("Result: FAILED");
    end
    $finish;
end

endmodule

`default_nettype wire

// ==== src/mini_vdp.sv ====
/*
 * mini_vdp top, wishbone classic slave plus 12-bit rgb video out
 * video trails the raster counters by three cycles
 * single clock domain, synchronous active high reset
 */
`default_nettype none
`timescale 1ns/1ps

module mini_vdp (
    input  wire logic                   clk,
    input  wire logic                   reset_i,
    input  wire logic                   wb_cyc_i,
    input  wire logic                   wb_stb_i,
    input  wire logic                   wb_we_i,
    input  wire logic [2:0]             wb_adr_i,
    input  wire vdp_bus_pkg::bus_word_t wb_dat_i,
    output vdp_bus_pkg::bus_word_t      wb_dat_o,
    output logic                        wb_ack_o,
    output logic [3:0]                  red_o,
    output logic [3:0]                  green_o,
    output logic [3:0]                  blue_o,
    output logic                        hsync_o,
    output logic                        vsync_o,
    output logic                        de_o,
    output logic                        intr_o
);

logic                        pal_we;
vdp_video_pkg::color_index_t pal_addr;
vdp_bus_pkg::bus_word_t      pal_wdata;
vdp_video_pkg::color_index_t pix_index;
logic                        pix_de, pix_hsync, pix_vsync;
logic                        vblank_strobe;

vram_port_if host_vram ();      // host_regs -> arbiter
vram_port_if video_vram ();     // scanout -> arbiter, has priority

host_regs host_regs_i (
    .clk(clk), .reset_i(reset_i),
    .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i), .wb_adr_i(wb_adr_i),
    .wb_dat_i(wb_dat_i), .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o),
    .mem(host_vram.requester),
    .pal_we_o(pal_we), .pal_addr_o(pal_addr), .pal_wdata_o(pal_wdata),
    .vblank_strobe_i(vblank_strobe), .intr_o(intr_o)
);

scanout scanout_i (
    .clk(clk), .reset_i(reset_i), .mem(video_vram.requester),
    .pix_index_o(pix_index), .pix_de_o(pix_de),
    .pix_hsync_o(pix_hsync), .pix_vsync_o(pix_vsync),
    .vblank_strobe_o(vblank_strobe)
);

vram_arbiter vram_arbiter_i (
    .clk(clk), .reset_i(reset_i),
    .video_port(video_vram.arbiter), .host_port(host_vram.arbiter)
);

palette_out palette_out_i (
    .clk(clk), .reset_i(reset_i),
    .pal_we_i(pal_we), .pal_addr_i(pal_addr), .pal_wdata_i(pal_wdata),
    .pix_index_i(pix_index), .pix_de_i(pix_de),
    .pix_hsync_i(pix_hsync), .pix_vsync_i(pix_vsync),
    .red_o(red_o), .green_o(green_o), .blue_o(blue_o),
    .hsync_o(hsync_o), .vsync_o(vsync_o), .de_o(de_o)
);

endmodule

`default_nettype wire

// ==== src/palette_out.sv ====
/*
 * palette ram with registered lookup and the output stage
 * adds one cycle, syncs and enable delayed to match
 * colour forced to black outside the visible area
 */
`default_nettype none
`timescale 1ns/1ps
`include "vdp_config.svh"

module palette_out (
    input  wire logic                        clk,
    input  wire logic                        reset_i,
    input  wire logic                        pal_we_i,
    input  wire vdp_video_pkg::color_index_t pal_addr_i,
    input  wire vdp_bus_pkg::bus_word_t      pal_wdata_i,     // only low 12 bits kept
    input  wire vdp_video_pkg::color_index_t pix_index_i,
    input  wire logic                        pix_de_i,
    input  wire logic                        pix_hsync_i,
    input  wire logic                        pix_vsync_i,
    output logic [3:0]                       red_o,
    output logic [3:0]                       green_o,
    output logic [3:0]                       blue_o,
    output logic                             hsync_o,
    output logic                             vsync_o,
    output logic                             de_o
);

vdp_video_pkg::rgb12_t pal_ram [2**`PAL_AW];
vdp_video_pkg::rgb12_t rgb_q;

// host write port
always_ff @(posedge clk) begin
    if (pal_we_i) begin
        pal_ram[pal_addr_i] <= pal_wdata_i[11:0];
    end
end

// lookup and blanking in one register stage
always_ff @(posedge clk) begin
    if (reset_i) begin
        rgb_q   <= '0;
        hsync_o <= 1'b0;
        vsync_o <= 1'b0;
        de_o    <= 1'b0;
    end else begin
        rgb_q   <= pix_de_i ? pal_ram[pix_index_i] : '0;   // black in blanking
        hsync_o <= pix_hsync_i;
        vsync_o <= pix_vsync_i;
        de_o    <= pix_de_i;
    end
end

assign red_o   = rgb_q[11:8];
assign green_o = rgb_q[7:4];
assign blue_o  = rgb_q[3:0];

endmodule

`default_nettype wire

// ==== src/vram_arbiter.sv ====
/*
 * single port video memory shared by scanout and host
 * fixed priority, video wins, host only gets idle cycles
 * grant is combinational, read data registered and shared by both ports
 */
`default_nettype none
`timescale 1ns/1ps
`include "vdp_config.svh"

module vram_arbiter (
    input  wire logic    clk,
    input  wire logic    reset_i,
    vram_port_if.arbiter video_port,
    vram_port_if.arbiter host_port
);

vdp_bus_pkg::bus_word_t  vram_q [2**`VRAM_AW];   // no reset, contents undefined at start
vdp_bus_pkg::bus_word_t  rd_q;
logic                    video_sel;              // video owns this cycle
logic                    acc_go;
logic                    acc_we;
vdp_bus_pkg::vram_addr_t acc_addr;
vdp_bus_pkg::bus_word_t  acc_wdata;

assign video_sel        = video_port.req;
assign video_port.grant = video_port.req;
assign host_port.grant  = host_port.req && !video_sel;

// muxed access, one per cycle
assign acc_go    = video_port.grant || host_port.grant;
assign acc_we    = video_sel ? video_port.we    : host_port.we;
assign acc_addr  = video_sel ? video_port.addr  : host_port.addr;
assign acc_wdata = video_sel ? video_port.wdata : host_port.wdata;

always_ff @(posedge clk) begin
    if (acc_go && acc_we) begin
        vram_q[acc_addr] <= acc_wdata;
    end
    if (acc_go && !acc_we) begin
        rd_q <= vram_q[acc_addr];   // holds until next read
    end
end

assign video_port.rdata = rd_q;
assign host_port.rdata  = rd_q;

// a waiting host access stays put until video lets it through
host_req_held: assert property (@(posedge clk) disable iff (reset_i)
    (host_port.req && !host_port.grant) |=>
        (host_port.req && $stable(host_port.addr) && $stable(host_port.we)
         && $stable(host_port.wdata)));

endmodule

`default_nettype wire

// ==== src/scanout.sv ====
/*
 * raster counters, sync decode and pixel fetch from video memory
 * one word per two visible pixels, high byte first
 * relies on the arbiter granting video in the cycle of the request
 * index and sync outputs run two cycles behind the counters
 */
`default_nettype none
`timescale 1ns/1ps
`include "vdp_config.svh"

module scanout (
    input  wire logic                   clk,
    input  wire logic                   reset_i,
    vram_port_if.requester              mem,            // video side of vram
    output vdp_video_pkg::color_index_t pix_index_o,
    output logic                        pix_de_o,
    output logic                        pix_hsync_o,
    output logic                        pix_vsync_o,
    output logic                        vblank_strobe_o
);

vdp_video_pkg::h_count_t     h_q;
vdp_video_pkg::v_count_t     v_q;
logic                        h_last, v_last;
logic                        visible;
logic                        hsync, vsync;
vdp_video_pkg::fetch_state_t state_q;
vdp_video_pkg::color_index_t lo_q;            // low byte waiting its turn
logic                        de_d1, hs_d1, vs_d1;

assign h_last  = (h_q == vdp_video_pkg::h_count_t'(`H_TOTAL - 1));
assign v_last  = (v_q == vdp_video_pkg::v_count_t'(`V_TOTAL - 1));
assign visible = (h_q < vdp_video_pkg::h_count_t'(`H_VISIBLE)) &&
                 (v_q < vdp_video_pkg::v_count_t'(`V_VISIBLE));
// sync windows sit after the front porch, active high
assign hsync = (h_q >= vdp_video_pkg::h_count_t'(`H_VISIBLE + `H_FRONT)) &&
               (h_q < vdp_video_pkg::h_count_t'(`H_VISIBLE + `H_FRONT + `H_SYNC));
assign vsync = (v_q >= vdp_video_pkg::v_count_t'(`V_VISIBLE + `V_FRONT)) &&
               (v_q < vdp_video_pkg::v_count_t'(`V_VISIBLE + `V_FRONT + `V_SYNC));

assign vblank_strobe_o = (h_q == '0) && (v_q == vdp_video_pkg::v_count_t'(`V_VISIBLE));

always_ff @(posedge clk) begin
    if (reset_i) begin
        h_q <= '0;
        v_q <= '0;
    end else begin
        h_q <= h_last ? '0 : h_q + 1'b1;
        if (h_last) begin
            v_q <= v_last ? '0 : v_q + 1'b1;
        end
    end
end

// word (y*H_VISIBLE + x)/2 at each even visible x
assign mem.req   = visible && !h_q[0];
assign mem.we    = 1'b0;                  // read only
assign mem.wdata = '0;
assign mem.addr  = vdp_bus_pkg::vram_addr_t'((32'(v_q) * `H_VISIBLE + 32'(h_q)) >> 1);

always_ff @(posedge clk) begin
    if (reset_i) begin
        state_q <= vdp_video_pkg::FETCH_IDLE;
    end else begin
        case (state_q)
            vdp_video_pkg::FETCH_IDLE: if (mem.grant) state_q <= vdp_video_pkg::FETCH_WAIT;
            vdp_video_pkg::FETCH_WAIT: state_q <= vdp_video_pkg::FETCH_HOLD;
            default: state_q <= mem.grant ? vdp_video_pkg::FETCH_WAIT   // back to back words
                                          : vdp_video_pkg::FETCH_IDLE;
        endcase
    end
end

// pixel index stream
always_ff @(posedge clk) begin
    if (state_q == vdp_video_pkg::FETCH_WAIT) begin
        pix_index_o <= mem.rdata[15:8];   // even pixel
        lo_q        <= mem.rdata[7:0];
    end else if (state_q == vdp_video_pkg::FETCH_HOLD) begin
        pix_index_o <= lo_q;              // odd pixel
    end
end

// two stage delay to line up with the index
always_ff @(posedge clk) begin
    if (reset_i) begin
        de_d1       <= 1'b0;
        hs_d1       <= 1'b0;
        vs_d1       <= 1'b0;
        pix_de_o    <= 1'b0;
        pix_hsync_o <= 1'b0;
        pix_vsync_o <= 1'b0;
    end else begin
        de_d1       <= visible;
        hs_d1       <= hsync;
        vs_d1       <= vsync;
        pix_de_o    <= de_d1;
        pix_hsync_o <= hs_d1;
        pix_vsync_o <= vs_d1;
    end
end

// request may not be withdrawn before the arbiter takes it
req_held: assert property (@(posedge clk) disable iff (reset_i)
    (mem.req && !mem.grant) |=> mem.req);

endmodule

`default_nettype wire

// ==== src/host_regs.sv ====
/*
 * wishbone classic slave with the host register file
 * master must drop stb for a cycle after each ack
 * vram data accesses wait for the arbiter, scanout always goes first
 * one interrupt source, vertical blank
 */
`default_nettype none
`timescale 1ns/1ps
`include "vdp_config.svh"

module host_regs (
    input  wire logic                         clk,
    input  wire logic                         reset_i,
    input  wire logic                         wb_cyc_i,
    input  wire logic                         wb_stb_i,
    input  wire logic                         wb_we_i,
    input  wire logic [2:0]                   wb_adr_i,
    input  wire vdp_bus_pkg::bus_word_t       wb_dat_i,
    output vdp_bus_pkg::bus_word_t            wb_dat_o,
    output logic                              wb_ack_o,
    vram_port_if.requester                    mem,          // host side of vram
    output logic                              pal_we_o,
    output vdp_video_pkg::color_index_t       pal_addr_o,
    output vdp_bus_pkg::bus_word_t            pal_wdata_o,
    input  wire logic                         vblank_strobe_i,
    output logic                              intr_o
);

vdp_bus_pkg::reg_num_t       reg_sel;
logic                        start;         // new cycle, not yet acked
logic                        reg_go;        // plain register access this cycle
logic                        int_clear;     // write of 1 to INT_CTRL bit 8
vdp_bus_pkg::vram_addr_t     vram_addr_q;
vdp_video_pkg::color_index_t pal_addr_q;
logic                        mask_q;
logic                        status_q;      // vblank pending

assign reg_sel   = vdp_bus_pkg::reg_num_t'(wb_adr_i);
assign start     = wb_cyc_i && wb_stb_i && !wb_ack_o;   // ack cycle blocks a retrigger
assign reg_go    = start && (reg_sel != vdp_bus_pkg::REG_VRAM_DATA);

// vram window, request stays up with stb until granted
assign mem.req   = start && (reg_sel == vdp_bus_pkg::REG_VRAM_DATA);
assign mem.we    = wb_we_i;
assign mem.addr  = vram_addr_q;
assign mem.wdata = wb_dat_i;

// palette write goes straight through, one pulse per bus write
assign pal_we_o    = reg_go && wb_we_i && (reg_sel == vdp_bus_pkg::REG_PAL_DATA);
assign pal_addr_o  = pal_addr_q;
assign pal_wdata_o = wb_dat_i;

assign int_clear = reg_go && wb_we_i && (reg_sel == vdp_bus_pkg::REG_INT_CTRL) && wb_dat_i[8];

always_ff @(posedge clk) begin
    if (reset_i) begin
        wb_ack_o    <= 1'b0;
        vram_addr_q <= '0;
        pal_addr_q  <= '0;
        mask_q      <= 1'b0;
        status_q    <= 1'b0;
        intr_o      <= 1'b0;
    end else begin
        wb_ack_o <= reg_go || mem.grant;                    // vram read data is there next cycle
        status_q <= (status_q && !int_clear) || vblank_strobe_i;  // set wins over clear
        intr_o   <= status_q && mask_q;
        if (mem.grant) begin
            vram_addr_q <= vram_addr_q + 1'b1;              // auto increment, read or write
        end
        if (reg_go) begin
            case (reg_sel)
                vdp_bus_pkg::REG_VRAM_ADDR: if (wb_we_i) vram_addr_q <= wb_dat_i[`VRAM_AW-1:0];
                vdp_bus_pkg::REG_PAL_ADDR:  if (wb_we_i) pal_addr_q <= wb_dat_i[`PAL_AW-1:0];
                vdp_bus_pkg::REG_PAL_DATA:  pal_addr_q <= pal_addr_q + 1'b1;
                vdp_bus_pkg::REG_INT_CTRL:  if (wb_we_i) mask_q <= wb_dat_i[0];
                default: ;                                  // unused numbers do nothing
            endcase
        end
    end
end

// read mux, adr is held through ack
always_comb begin
    wb_dat_o = '0;
    case (reg_sel)
        vdp_bus_pkg::REG_VRAM_ADDR: wb_dat_o[`VRAM_AW-1:0] = vram_addr_q;
        vdp_bus_pkg::REG_VRAM_DATA: wb_dat_o = mem.rdata;      // valid in ack cycle
        vdp_bus_pkg::REG_PAL_ADDR:  wb_dat_o[`PAL_AW-1:0] = pal_addr_q;
        vdp_bus_pkg::REG_INT_CTRL: begin
            wb_dat_o[0] = mask_q;
            wb_dat_o[8] = status_q;
        end
        default: ;                                          // PAL_DATA reads zero
    endcase
end

// ack only inside a cycle the master still holds
ack_in_cycle: assert property (@(posedge clk) disable iff (reset_i)
    wb_ack_o |-> (wb_cyc_i && wb_stb_i));

endmodule

`default_nettype wire

// ==== src/vram_port_if.sv ====
/*
 * one requester's access to video memory
 * requester holds req, we, addr and wdata steady until grant
 * grant is one cycle, read data follows a cycle later and holds
 */
`default_nettype none
`timescale 1ns/1ps

interface vram_port_if ();

    logic                    req;      // held until grant
    logic                    we;       // 1 = write
    vdp_bus_pkg::vram_addr_t addr;
    vdp_bus_pkg::bus_word_t  wdata;
    logic                    grant;    // access happens this cycle
    vdp_bus_pkg::bus_word_t  rdata;    // valid the cycle after grant

    modport requester (output req, we, addr, wdata, input grant, rdata);
    modport arbiter (input req, we, addr, wdata, output grant, rdata);

endinterface

`default_nettype wire

// ==== src/vdp_video_pkg.sv ====
/*
 * video side types: raster counters, colour index and colour word
 * counters are 5 bits, enough for the 24 x 12 raster only
 */
`include "vdp_config.svh"

package vdp_video_pkg;

    typedef logic [4:0] h_count_t;  // 0 .. H_TOTAL-1
    typedef logic [4:0] v_count_t;  // 0 .. V_TOTAL-1

    // palette index, one per pixel, two per vram word
    typedef logic [`PAL_AW-1:0] color_index_t;

    // 4:4:4 colour, red in [11:8], green [7:4], blue [3:0]
    typedef logic [11:0] rgb12_t;

    // scanout fetch phase
    typedef enum logic [1:0] {
        FETCH_IDLE, // nothing in flight
        FETCH_WAIT, // granted, read data lands next cycle
        FETCH_HOLD  // high byte out, low byte kept
    } fetch_state_t;

endpackage

// ==== src/vdp_bus_pkg.sv ====
/*
 * host side types: bus word, video memory address and register numbers
 * register numbers 5 to 7 are unused, they ack and read as zero
 */
`include "vdp_config.svh"

package vdp_bus_pkg;

    // host data word, also the video memory word
    typedef logic [`DATA_W-1:0] bus_word_t;

    // video memory word address
    typedef logic [`VRAM_AW-1:0] vram_addr_t;

    // wishbone register map, word addressed
    typedef enum logic [2:0] {
        REG_VRAM_ADDR = 3'd0,   // vram word address, auto increment
        REG_VRAM_DATA = 3'd1,   // vram data window
        REG_PAL_ADDR  = 3'd2,   // palette entry address
        REG_PAL_DATA  = 3'd3,   // palette data, write only
        REG_INT_CTRL  = 3'd4    // bit 0 mask, bit 8 status / clear
    } reg_num_t;

endpackage

// ==== src/vdp_config.svh ====
/*
 * raster timing, memory depths and word widths for the whole design
 * the raster is tiny on purpose and drives no real monitor
 * widths are fixed, no module is checked at other values
 */
`ifndef VDP_CONFIG_SVH
`define VDP_CONFIG_SVH

// horizontal sections, in pixels
`define H_VISIBLE 16
`define H_FRONT   2
`define H_SYNC    3
`define H_BACK    3
`define H_TOTAL   (`H_VISIBLE + `H_FRONT + `H_SYNC + `H_BACK)   // 24

// vertical sections, in lines
`define V_VISIBLE 8
`define V_FRONT   1
`define V_SYNC    2
`define V_BACK    1
`define V_TOTAL   (`V_VISIBLE + `V_FRONT + `V_SYNC + `V_BACK)   // 12, 288 cycles/frame

`define VRAM_AW   8     // 256 words of video memory
`define PAL_AW    8     // 256 palette entries
`define DATA_W    16    // host bus and memory word

`endif
